// File: logic/fpu_pkg.sv
// --------------------------------------------------------------------------
// FPU package: widths, operation encodings and request/response types for
// the single-precision non-computational FPU
// --------------------------------------------------------------------------
package fpu_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int unsigned FLEN          = 32;  // FP32 only
    localparam int unsigned TRANS_ID_BITS = 3;   // Scoreboard tag
    localparam int unsigned STATUS_BITS   = 5;   // {NV, DZ, OF, UF, NX}

    // Canonical quiet NaN, positive sign
    localparam logic [FLEN-1:0] CANON_NAN = 32'h7fc0_0000;

    // Operations as issued
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,  // rm selects J / JN / JX
        FMIN_MAX = 3'd1,  // rm selects MIN / MAX
        FCMP     = 3'd2,  // rm selects LE / LT / EQ
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,
        FMV_X2F  = 3'd5
    } fpu_op_e;

    // Operations inside the unit
    typedef enum logic [2:0] {
        SGNJ     = 3'd0,
        MINMAX   = 3'd1,
        CMP      = 3'd2,
        CLASSIFY = 3'd3,
        MOVE     = 3'd4
    } unit_op_e;

    // Bit positions of the RISC-V class mask
    typedef enum logic [3:0] {
        CLS_NEG_INF     = 4'd0,
        CLS_NEG_NORM    = 4'd1,
        CLS_NEG_SUBNORM = 4'd2,
        CLS_NEG_ZERO    = 4'd3,
        CLS_POS_ZERO    = 4'd4,
        CLS_POS_SUBNORM = 4'd5,
        CLS_POS_NORM    = 4'd6,
        CLS_POS_INF     = 4'd7,
        CLS_SNAN        = 4'd8,
        CLS_QNAN        = 4'd9
    } fpu_class_e;

    // ----------------------------------------------------------------------
    // Unit request and response
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [TRANS_ID_BITS-1:0] tag;
        unit_op_e                 op;
        logic [1:0]               sub_op;     // Low rm bits
        logic                     illegal;    // Bad rm for this operation
        logic [FLEN-1:0]          operand_a;
        logic [FLEN-1:0]          operand_b;
    } fpu_req_t;

    typedef struct packed {
        logic [TRANS_ID_BITS-1:0] tag;
        logic [FLEN-1:0]          result;
        logic [STATUS_BITS-1:0]   status;     // Only NV is ever set
    } fpu_resp_t;

endpackage

// File: logic/fpu_op_decoder.sv
// --------------------------------------------------------------------------
// FPU operation decoder: maps the issued operation and rm field onto a
// unit request, flagging rm values an operation does not define
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module fpu_op_decoder (
    input  fpu_pkg::fpu_op_e                       fpu_op_i,
    input  logic [2:0]                             fpu_rm_i,     // Sub-op select
    input  logic [fpu_pkg::FLEN-1:0]               operand_a_i,
    input  logic [fpu_pkg::FLEN-1:0]               operand_b_i,
    input  logic [fpu_pkg::TRANS_ID_BITS-1:0]      trans_id_i,
    output fpu_pkg::fpu_req_t                      req_o
);
    import fpu_pkg::*;

    always_comb begin : p_decode
        // Defaults, operands and tag pass straight through
        req_o.tag       = trans_id_i;
        req_o.operand_a = operand_a_i;
        req_o.operand_b = operand_b_i;
        req_o.op        = SGNJ;
        req_o.sub_op    = fpu_rm_i[1:0];
        req_o.illegal   = 1'b0;

        case (fpu_op_i)
            // J / JN / JX in rm 0..2
            FSGNJ: begin
                req_o.op      = SGNJ;
                req_o.illegal = fpu_rm_i > 3'd2;
            end
            // MIN = 0, MAX = 1
            FMIN_MAX: begin
                req_o.op      = MINMAX;
                req_o.illegal = fpu_rm_i > 3'd1;
            end
            // LE = 0, LT = 1, EQ = 2
            FCMP: begin
                req_o.op      = CMP;
                req_o.illegal = fpu_rm_i > 3'd2;
            end
            FCLASS: begin
                req_o.op     = CLASSIFY;
                req_o.sub_op = 2'd0;           // rm has no meaning here
            end
            // Both moves are a bit-exact copy of a
            FMV_F2X, FMV_X2F: begin
                req_o.op     = MOVE;
                req_o.sub_op = 2'd0;
            end
            default: begin
                req_o.illegal = 1'b1;          // Unused opcode
            end
        endcase
    end

endmodule

// File: logic/fpu_issue_buffer.sv
// --------------------------------------------------------------------------
// FPU issue buffer: accepts an instruction optimistically and replays it
// from a hold register while the operand stage stalls
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module fpu_issue_buffer (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              valid_i,   // From the issuer
    output logic              ready_o,
    input  fpu_pkg::fpu_req_t req_i,
    output logic              valid_o,   // Towards the operand stage
    input  logic              ready_i,
    output fpu_pkg::fpu_req_t req_o
);
    import fpu_pkg::*;

    typedef enum logic {
        READY,
        STALL
    } state_e;

    state_e   state_q, state_d;
    fpu_req_t hold_q;                    // Request replayed during STALL
    logic     hold_en;
    logic     use_hold;

    // ----------------------------------------------------------------------
    // Protocol inversion FSM
    // ----------------------------------------------------------------------
    always_comb begin : p_fsm
        ready_o  = 1'b0;
        valid_o  = 1'b0;
        hold_en  = 1'b0;
        use_hold = 1'b0;
        state_d  = state_q;

        case (state_q)
            READY: begin
                ready_o = 1'b1;          // Claim ready up front
                valid_o = valid_i;
                // Operand stage full, take the token back and keep a copy
                if (valid_i && !ready_i) begin
                    ready_o = 1'b0;
                    hold_en = 1'b1;
                    state_d = STALL;
                end
            end
            STALL: begin
                valid_o  = 1'b1;
                use_hold = 1'b1;
                if (ready_i) begin
                    ready_o = 1'b1;      // Held request leaves this cycle
                    state_d = READY;
                end
            end
            default: state_d = READY;
        endcase

        if (flush_i) state_d = READY;    // Flush drops the held request
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin : p_hold
        if (hold_en) hold_q <= req_i;
    end

    assign req_o = use_hold ? hold_q : req_i;

    // Issuer stays blocked and the held request stays put until the stage frees up
    a_stall_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == STALL && !ready_i && !flush_i) |->
            (!ready_o ##1 (state_q == STALL && $stable(req_o))));

endmodule

// File: logic/fpu_pipe_reg.sv
// --------------------------------------------------------------------------
// One-entry valid/ready pipeline register with flush
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module fpu_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     flush_i,     // Drops the entry at the next edge
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // Empty, or the entry leaves in this cycle
    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin : p_data
        if (valid_i && ready_o) data_q <= data_i;
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

    // A stalled entry must not change under the consumer
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_o && !ready_i && !flush_i) |=> (valid_o && $stable(data_o)));

endmodule

// File: logic/fpu_noncomp_unit.sv
// --------------------------------------------------------------------------
// FP32 non-computational unit: sign injection, min/max, compare, classify
// and move, with the invalid-operation flag
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module fpu_noncomp_unit (
    input  fpu_pkg::fpu_req_t  req_i,
    output fpu_pkg::fpu_resp_t resp_o
);
    import fpu_pkg::*;

    typedef struct packed {
        logic sign;
        logic zero;
        logic subnorm;
        logic inf;
        logic snan;
        logic qnan;
    } fp_info_t;

    // Field decode of one FP32 value
    function automatic fp_info_t fp_info(input logic [FLEN-1:0] x);
        fp_info_t info;
        logic     exp_ones;
        logic     exp_zero;
        logic     man_zero;
        exp_ones     = &x[30:23];
        exp_zero     = ~|x[30:23];
        man_zero     = ~|x[22:0];
        info.sign    = x[FLEN-1];
        info.zero    = exp_zero && man_zero;
        info.subnorm = exp_zero && !man_zero;
        info.inf     = exp_ones && man_zero;
        info.snan    = exp_ones && !man_zero && !x[22];  // Quiet bit clear
        info.qnan    = exp_ones && x[22];
        return info;
    endfunction

    function automatic fpu_class_e class_of(input fp_info_t i);
        if (i.snan) return CLS_SNAN;
        if (i.qnan) return CLS_QNAN;
        if (i.inf) return i.sign ? CLS_NEG_INF : CLS_POS_INF;
        if (i.zero) return i.sign ? CLS_NEG_ZERO : CLS_POS_ZERO;
        if (i.subnorm) return i.sign ? CLS_NEG_SUBNORM : CLS_POS_SUBNORM;
        return i.sign ? CLS_NEG_NORM : CLS_POS_NORM;
    endfunction

    logic [FLEN-1:0] op_a, op_b;
    fp_info_t        info_a, info_b;
    logic            a_nan, b_nan, any_nan, any_snan;
    logic            a_lt_b, a_eq_b;
    logic [FLEN-1:0] result;
    logic            nv;

    assign op_a     = req_i.operand_a;
    assign op_b     = req_i.operand_b;
    assign info_a   = fp_info(op_a);
    assign info_b   = fp_info(op_b);
    assign a_nan    = info_a.snan || info_a.qnan;
    assign b_nan    = info_b.snan || info_b.qnan;
    assign any_nan  = a_nan || b_nan;
    assign any_snan = info_a.snan || info_b.snan;
    assign a_eq_b   = (op_a == op_b) || (info_a.zero && info_b.zero);  // -0 == +0

    // ----------------------------------------------------------------------
    // Ordering on sign-magnitude, -0 below +0
    // ----------------------------------------------------------------------
    always_comb begin : p_order
        if (info_a.sign != info_b.sign) begin
            a_lt_b = info_a.sign;
        end else if (info_a.sign) begin
            a_lt_b = op_a[FLEN-2:0] > op_b[FLEN-2:0];  // Both negative
        end else begin
            a_lt_b = op_a[FLEN-2:0] < op_b[FLEN-2:0];
        end
    end

    // ----------------------------------------------------------------------
    // Result and NV
    // ----------------------------------------------------------------------
    always_comb begin : p_datapath
        result = '0;
        nv     = 1'b0;
        if (req_i.illegal) begin
            nv = 1'b1;                                   // Zero result
        end else begin
            case (req_i.op)
                SGNJ: begin
                    case (req_i.sub_op)
                        2'd0:    result = {info_b.sign, op_a[FLEN-2:0]};
                        2'd1:    result = {!info_b.sign, op_a[FLEN-2:0]};
                        default: result = {info_a.sign ^ info_b.sign, op_a[FLEN-2:0]};
                    endcase
                end
                MINMAX: begin
                    nv = any_snan;
                    if (a_nan && b_nan) result = CANON_NAN;
                    else if (a_nan) result = op_b;       // NaN loses
                    else if (b_nan) result = op_a;
                    else if (req_i.sub_op[0]) result = a_lt_b ? op_b : op_a;  // MAX
                    else result = a_lt_b ? op_a : op_b;  // MIN
                end
                CMP: begin
                    case (req_i.sub_op)
                        2'd0: begin                      // LE, signalling
                            nv        = any_nan;
                            result[0] = !any_nan && (a_lt_b || a_eq_b);
                        end
                        2'd1: begin                      // LT, signalling
                            nv        = any_nan;
                            result[0] = !any_nan && a_lt_b && !a_eq_b;
                        end
                        default: begin                   // EQ, quiet
                            nv        = any_snan;
                            result[0] = !any_nan && a_eq_b;
                        end
                    endcase
                end
                CLASSIFY: result[class_of(info_a)] = 1'b1;
                MOVE:     result = op_a;
                default:  nv = 1'b1;
            endcase
        end
    end

    assign resp_o.tag    = req_i.tag;
    assign resp_o.result = result;
    assign resp_o.status = {nv, 4'b0000};

    // Bad encodings must reach writeback as zero with NV
    always_comb begin : p_illegal_check
        if (req_i.illegal) begin
            assert (resp_o.result == '0 && resp_o.status[STATUS_BITS-1]);
        end
    end

endmodule

// File: logic/fpu_top.sv
// --------------------------------------------------------------------------
// FPU top: decoder, issue buffer, operand stage, unit and result stage
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module fpu_top (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    // Issue side
    input  logic                                fpu_valid_i,
    output logic                                fpu_ready_o,
    input  fpu_pkg::fpu_op_e                    fpu_op_i,
    input  logic [2:0]                          fpu_rm_i,
    input  logic [fpu_pkg::FLEN-1:0]            operand_a_i,
    input  logic [fpu_pkg::FLEN-1:0]            operand_b_i,
    input  logic [fpu_pkg::TRANS_ID_BITS-1:0]   trans_id_i,
    // Writeback side
    output logic                                fpu_valid_o,
    output logic [fpu_pkg::FLEN-1:0]            result_o,
    output logic [fpu_pkg::TRANS_ID_BITS-1:0]   fpu_trans_id_o,
    output logic [fpu_pkg::STATUS_BITS-1:0]     fpu_status_o,
    input  logic                                result_ready_i
);
    import fpu_pkg::*;

    fpu_req_t  dec_req, buf_req, opr_req;
    logic      buf_valid, opr_ready;       // Buffer to operand stage
    logic      opr_valid, res_ready;       // Operand stage to result stage
    fpu_resp_t unit_resp, res_resp;

    fpu_op_decoder u_op_decoder (
        .fpu_op_i, .fpu_rm_i, .operand_a_i, .operand_b_i, .trans_id_i,
        .req_o       (dec_req)
    );

    fpu_issue_buffer u_issue_buffer (
        .clk_i, .rst_ni, .flush_i,
        .valid_i (fpu_valid_i), .ready_o (fpu_ready_o), .req_i (dec_req),
        .valid_o (buf_valid),   .ready_i (opr_ready),   .req_o (buf_req)
    );

    fpu_pipe_reg #(.payload_t(fpu_req_t)) u_operand_stage (
        .clk_i, .rst_ni, .flush_i,
        .valid_i (buf_valid), .ready_o (opr_ready), .data_i (buf_req),
        .valid_o (opr_valid), .ready_i (res_ready), .data_o (opr_req)
    );

    fpu_noncomp_unit u_noncomp_unit (.req_i (opr_req), .resp_o (unit_resp));

    fpu_pipe_reg #(.payload_t(fpu_resp_t)) u_result_stage (
        .clk_i, .rst_ni, .flush_i,
        .valid_i (opr_valid),   .ready_o (res_ready),      .data_i (unit_resp),
        .valid_o (fpu_valid_o), .ready_i (result_ready_i), .data_o (res_resp)
    );

    assign result_o       = res_resp.result;
    assign fpu_trans_id_o = res_resp.tag;
    assign fpu_status_o   = res_resp.status;

endmodule

// File: test/fpu_model.svh
// --------------------------------------------------------------------------
// FPU reference model: FP32 classification and the expected unit response
// --------------------------------------------------------------------------
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

// Maps sign-magnitude onto an unsigned order, -0 sits just below +0
function automatic logic [FLEN-1:0] order_key(input logic [FLEN-1:0] x);
    return x[31] ? ~x : (x | 32'h8000_0000);
endfunction

function automatic logic is_nan(input logic [FLEN-1:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
endfunction

function automatic logic is_snan(input logic [FLEN-1:0] x);
    return is_nan(x) && !x[22];           // Quiet bit clear
endfunction

function automatic logic [FLEN-1:0] class_mask(input logic [FLEN-1:0] x);
    logic [FLEN-1:0] m;
    m = '0;
    if (x[30:23] == 8'hff) begin
        if (x[22:0] == 23'd0) m[x[31] ? 0 : 7] = 1'b1;   // Infinities
        else m[x[22] ? 9 : 8] = 1'b1;                    // qNaN or sNaN
    end else if (x[30:23] == 8'h00) begin
        if (x[22:0] == 23'd0) m[x[31] ? 3 : 4] = 1'b1;   // Zeros
        else m[x[31] ? 2 : 5] = 1'b1;                    // Subnormals
    end else begin
        m[x[31] ? 1 : 6] = 1'b1;
    end
    return m;
endfunction

function automatic fpu_resp_t expected_resp(input fpu_op_e op, input logic [2:0] rm,
        input logic [FLEN-1:0] a, input logic [FLEN-1:0] b,
        input logic [TRANS_ID_BITS-1:0] tag);
    fpu_resp_t r;
    logic      nan_ab, lt, eq, nv;
    nan_ab   = is_nan(a) || is_nan(b);
    lt       = order_key(a) < order_key(b);
    eq       = (a == b) || ((a[30:0] == 31'd0) && (b[30:0] == 31'd0));
    nv       = 1'b0;
    r.tag    = tag;
    r.result = '0;
    if (((op == FSGNJ || op == FCMP) && rm > 3'd2) || (op == FMIN_MAX && rm > 3'd1)) begin
        nv = 1'b1;                                       // Undefined rm
    end else begin
        case (op)
            FSGNJ: r.result = {(rm == 3'd0) ? b[31] : (rm == 3'd1) ? ~b[31] : a[31] ^ b[31],
                               a[30:0]};
            FMIN_MAX: begin
                nv = is_snan(a) || is_snan(b);
                if (is_nan(a) && is_nan(b)) r.result = CANON_NAN;
                else if (is_nan(a)) r.result = b;
                else if (is_nan(b)) r.result = a;
                else r.result = ((rm == 3'd1) ^ lt) ? a : b;   // MAX takes the larger
            end
            FCMP: begin
                nv = (rm == 3'd2) ? (is_snan(a) || is_snan(b)) : nan_ab;
                r.result[0] = !nan_ab && ((rm == 3'd0) ? (lt || eq) :
                                          (rm == 3'd1) ? (lt && !eq) : eq);
            end
            FCLASS:  r.result = class_mask(a);
            default: r.result = a;                       // Both moves
        endcase
    end
    r.status = {nv, 4'b0000};
    return r;
endfunction

`endif

// File: test/tb_fpu_top.sv
// --------------------------------------------------------------------------
// FPU top testbench: random issue against a model, back-pressure and flush
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_fpu_top;
    import fpu_pkg::*;
    `include "fpu_model.svh"

    localparam logic [31:0] SEED  = 32'h9ba1_4d33;
    localparam int          LIMIT = 200;           // Cycles per wait

    logic clk_i, rst_ni, flush_i, fpu_valid_i, fpu_ready_o, fpu_valid_o;
    logic result_ready_i = 1'b1;
    fpu_op_e fpu_op_i;
    logic [2:0] fpu_rm_i, trans_id_i, fpu_trans_id_o, next_tag;
    logic [FLEN-1:0] operand_a_i, operand_b_i, result_o;
    logic [STATUS_BITS-1:0] fpu_status_o;

    integer    seed, ready_seed;
    logic [1:0] rr_mode;                           // 0 low, 1 high, 2 random
    fpu_resp_t exp_q[$];
    fpu_resp_t held;
    logic      hold_armed;
    int        check_cnt, err_cnt, chk0, err0;

    fpu_top u_fpu_top (.*);

    initial begin : p_clock
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Writeback back-pressure
    always @(posedge clk_i) begin : p_ready
        logic [31:0] r;
        r = $random(ready_seed);
        result_ready_i <= (rr_mode == 2'd2) ? r[0] : (rr_mode == 2'd1);
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
        check_cnt++;
        if (got !== expv) begin
            err_cnt++;
            $display("ERR %0t %s: got %h, expected %h", $time, name, got, expv);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt + 1);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // ----------------------------------------------------------------------
    // Monitor, sampled mid-cycle where everything is settled
    // ----------------------------------------------------------------------
    always @(negedge clk_i) begin : p_monitor
        fpu_resp_t expv;
        if (hold_armed) begin                      // Stalled output must not move
            check_value("fpu_valid_o held", 32'(fpu_valid_o), 32'd1);
            check_value("result_o held", result_o, held.result);
            check_value("fpu_trans_id_o held", 32'(fpu_trans_id_o), 32'(held.tag));
            check_value("fpu_status_o held", 32'(fpu_status_o), 32'(held.status));
        end
        hold_armed  = rst_ni && fpu_valid_o && !result_ready_i && !flush_i;
        held.tag    = fpu_trans_id_o;
        held.result = result_o;
        held.status = fpu_status_o;
        if (flush_i) begin
            exp_q.delete();                        // Everything in flight is dropped
        end else if (rst_ni && fpu_valid_o && result_ready_i) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Result with tag %0d at %0t has no outstanding instruction",
                         fpu_trans_id_o, $time);
            end else begin
                expv = exp_q.pop_front();
                check_value("result_o", result_o, expv.result);
                check_value("fpu_trans_id_o", 32'(fpu_trans_id_o), 32'(expv.tag));
                check_value("fpu_status_o", 32'(fpu_status_o), 32'(expv.status));
            end
        end
        if (rst_ni && fpu_valid_i && fpu_ready_o && !flush_i)
            exp_q.push_back(expected_resp(fpu_op_i, fpu_rm_i, operand_a_i, operand_b_i,
                                          trans_id_i));
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic logic [FLEN-1:0] rand_operand();
        logic [31:0] r;
        r = $random(seed);
        case (rand_below(6))
            1: return {r[31], 31'd0};                        // Zero
            2: return {r[31], 8'hff, 23'd0};                 // Infinity
            3: return {r[31], 8'hff, 1'b1, r[21:0]};         // Quiet NaN
            4: return {r[31], 8'hff, 1'b0, r[21:1], 1'b1};   // Signalling NaN
            5: return {r[31], 8'h00, r[22:1], 1'b1};         // Subnormal
            default: return r;
        endcase
    endfunction

    // Presents one instruction and waits for its acceptance
    task automatic issue(input fpu_op_e op, input int rm, input logic blocked);
        int waited;
        logic [FLEN-1:0] a;
        waited = 0;
        a = rand_operand();
        @(posedge clk_i);
        fpu_valid_i <= 1'b1;
        fpu_op_i    <= op;
        fpu_rm_i    <= rm[2:0];
        operand_a_i <= a;
        operand_b_i <= (rand_below(8) == 0) ? a : rand_operand();  // Equal pairs too
        trans_id_i  <= next_tag;
        next_tag     = next_tag + 3'd1;
        @(negedge clk_i);
        if (blocked) begin                         // Both stages full by now
            check_value("fpu_ready_o", 32'(fpu_ready_o), 32'd0);
            rr_mode <= 2'd2;
        end
        while (!fpu_ready_o) begin
            waited++;
            if (waited > LIMIT) stop_on_timeout("instruction never accepted");
            @(negedge clk_i);
        end
    endtask

    // Kinds: 0 sign-inject/move, 1 min-max/compare, 2 classify/bad rm, 3 any
    task automatic run_random(input int count, input int kind);
        int k;
        for (int i = 0; i < count; i++) begin
            k = rand_below(4);
            case (kind)
                0: issue((k == 0) ? FMV_F2X : (k == 1) ? FMV_X2F : FSGNJ, rand_below(3), 0);
                1: issue(k[0] ? FCMP : FMIN_MAX, rand_below(k[0] ? 3 : 2), 0);
                2: issue((k == 0) ? FCLASS : (k == 1) ? FSGNJ : (k == 2) ? FMIN_MAX : FCMP,
                         (k == 2) ? 2 + rand_below(6) : (k == 0) ? rand_below(8) : 3 + rand_below(5), 0);
                default: issue(fpu_op_e'(rand_below(6)), rand_below(8), 0);
            endcase
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk_i);
        fpu_valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > LIMIT) stop_on_timeout("results missing at the output");
            @(posedge clk_i);
        end
    endtask

    task automatic end_test(input string name);
        $display("%-16s done: %0d checks, %0d errors", name, check_cnt - chk0, err_cnt - err0);
        chk0 = check_cnt;
        err0 = err_cnt;
    endtask

    initial begin : p_main
        int waited;
        seed        = SEED;
        ready_seed  = SEED ^ 32'h0f0f_0f0f;
        rr_mode     = 2'd1;
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        fpu_valid_i = 1'b0;
        fpu_op_i    = FSGNJ;
        fpu_rm_i    = 3'd0;
        operand_a_i = '0;
        operand_b_i = '0;
        trans_id_i  = '0;
        next_tag    = '0;
        hold_armed  = 1'b0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;

        run_random(60, 0);
        drain();
        end_test("sgnj_move");
        run_random(120, 1);
        drain();
        end_test("minmax_cmp");
        run_random(60, 2);
        drain();
        end_test("class_illegal");

        rr_mode <= 2'd0;                           // Fill both stages
        repeat (2) @(posedge clk_i);
        issue(FCLASS, 0, 0);
        issue(FSGNJ, 1, 0);
        issue(FCMP, 2, 1);
        run_random(150, 3);
        drain();
        end_test("backpressure");

        rr_mode <= 2'd1;
        repeat (3) @(posedge clk_i);
        waited = 0;
        issue(FMV_X2F, 0, 0);
        @(posedge clk_i);
        fpu_valid_i <= 1'b0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (!fpu_valid_o && waited < 20);
        check_value("latency", 32'(waited), 32'd2);
        drain();
        end_test("latency");

        rr_mode <= 2'd0;                           // Two instructions in flight
        repeat (2) @(posedge clk_i);
        issue(FMIN_MAX, 1, 0);
        issue(FSGNJ, 2, 0);
        @(posedge clk_i);
        fpu_valid_i <= 1'b0;
        flush_i     <= 1'b1;
        @(posedge clk_i);
        flush_i     <= 1'b0;
        rr_mode     <= 2'd1;
        repeat (5) begin
            @(negedge clk_i);
            check_value("fpu_valid_o", 32'(fpu_valid_o), 32'd0);
        end
        run_random(40, 3);
        drain();
        end_test("flush");

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: fpu_noncomp.f
+incdir+test
logic/fpu_pkg.sv
logic/fpu_op_decoder.sv
logic/fpu_issue_buffer.sv
logic/fpu_pipe_reg.sv
logic/fpu_noncomp_unit.sv
logic/fpu_top.sv
test/tb_fpu_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the FPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_fpu_top -f fpu_noncomp.f
./obj_dir/Vtb_fpu_top > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
else
    exit 1
fi
